/* files.f */
logic/nnTypesPkg.sv
logic/olCtrlPkg.sv
logic/outLayerAgu.sv
logic/weightMem.sv
logic/pixelBuf.sv
logic/macUnit.sv
logic/argmaxSel.sv
logic/layerSeq.sv
logic/outLayerTop.sv
dv/tbClock.sv
dv/outLayer_assert.sv
dv/outLayerTb.sv

/* dv/outLayerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module outLayerTb import nnTypesPkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int RUN_COUNT       = 5;
    // Full weight load plus three pixel loads and two tie rows
    localparam int LOAD_CYCLES     = NUM_TAPS * (NUM_NEURONS + 5);
    localparam int WATCHDOG_CYCLES = RUN_COUNT * 400 + LOAD_CYCLES;

    logic                     Clk;
    logic                     rstN;
    logic                     resetReq;
    weightWrT                 weightWr;
    pixelWrT                  pixelWr;
    logic                     start;
    logic                     busy;
    logic                     done;
    neuronScoreT              score;
    logic [NEURON_W-1:0]      classIdx;
    logic signed [ACC_W-1:0]  classScore;

    logic [31:0]              lfsr = 32'had38_ba9c;
    logic signed [DATA_W-1:0] wModel [NUM_TAPS*NUM_NEURONS];
    logic signed [DATA_W-1:0] pModel [NUM_TAPS];
    int                       expScore [NUM_NEURONS];
    int                       expIdx;
    int                       expMax;

    tbClock #(.PeriodNs(CLK_PERIOD), .ResetCycles(2)) clockGen (
        .resetReq (resetReq),
        .Clk      (Clk),
        .rstN     (rstN)
    );

    outLayerTop UUT (
        .Clk        (Clk),
        .rstN       (rstN),
        .weightWr   (weightWr),
        .pixelWr    (pixelWr),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .score      (score),
        .classIdx   (classIdx),
        .classScore (classScore)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////
    // Galois LFSR on x^32 + x^22 + x^2 + x + 1
    function automatic logic randBit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [DATA_W-1:0] randByte();
        logic [DATA_W-1:0] b;
        for (int i = 0; i < DATA_W; i++) begin
            b = {b[DATA_W-2:0], randBit()};
        end
        return b;
    endfunction

    function automatic int unsigned boundFailures();
        return UUT.topChecks.failCount + UUT.uAgu.aguChecks.failCount;
    endfunction

    task automatic failRun(input string why);
        $display("TEST FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic mismatch(input string sigName, input int expected, input int actual);
        $display("[ERROR] %0t %s expected %0d actual %0d", $time, sigName, expected, actual);
        failRun("output value differs from the model");
    endtask

    task automatic writeWeight(input int addr, input logic signed [DATA_W-1:0] val);
        @(posedge Clk);
        #2;
        weightWr = '{en: 1'b1, addr: W_ADDR_W'(addr), data: val};
        wModel[addr] = val;
    endtask

    task automatic writePixel(input int idx, input logic signed [DATA_W-1:0] val);
        @(posedge Clk);
        #2;
        pixelWr = '{en: 1'b1, idx: TAP_W'(idx), data: val};
        pModel[idx] = val;
    endtask

    task automatic stopWrites();
        @(posedge Clk);
        #2;
        weightWr = '0;
        pixelWr  = '0;
    endtask

    task automatic loadPixels();
        for (int t = 0; t < NUM_TAPS; t++) begin
            writePixel(t, randByte());
        end
        stopWrites();
    endtask

    // Rows 3 and 7 get the largest possible product on every tap
    task automatic loadTieRows();
        for (int t = 0; t < 2 * NUM_TAPS; t++) begin
            writeWeight(((t < NUM_TAPS) ? 3 : 7 - 1) * NUM_TAPS + t,
                        (pModel[t % NUM_TAPS] < 0) ? 8'h80 : 8'h7f);
        end
        stopWrites();
    endtask

    task automatic computeModel();
        for (int n = 0; n < NUM_NEURONS; n++) begin
            expScore[n] = 0;
            for (int t = 0; t < NUM_TAPS; t++) begin
                expScore[n] += int'(wModel[n*NUM_TAPS + t]) * int'(pModel[t]);
            end
            // Strictly greater so a tie keeps the lower index
            if (n == 0 || expScore[n] > expMax) begin
                expIdx = n;
                expMax = expScore[n];
            end
        end
    endtask

    task automatic runLayer(input bit extraStart);
        int scoreCount;
        int cycles;
        bit finished;
        int got;
        scoreCount = 0;
        cycles     = 0;
        finished   = 1'b0;
        computeModel();
        @(posedge Clk);
        #2;
        start = 1'b1;
        @(negedge Clk);
        assert (!busy) else mismatch("busy", 0, busy);
        while (!finished) begin
            @(posedge Clk);
            #2;
            // Second start mid-run must be ignored
            start = extraStart && (cycles == 40);
            cycles++;
            @(negedge Clk);
            if (cycles == 1) begin
                assert (busy) else mismatch("busy", 1, busy);
            end
            if (score.valid) begin
                if (scoreCount >= NUM_NEURONS) begin
                    failRun("more than ten scores in one run");
                end
                got = score.value;
                assert (score.idx == NEURON_W'(scoreCount))
                    else mismatch("score.idx", scoreCount, score.idx);
                assert (got == expScore[scoreCount])
                    else mismatch("score.value", expScore[scoreCount], got);
                scoreCount++;
            end
            if (done) begin
                assert (scoreCount == NUM_NEURONS)
                    else mismatch("score count", NUM_NEURONS, scoreCount);
                assert (classIdx == NEURON_W'(expIdx)) else mismatch("classIdx", expIdx, classIdx);
                assert (classScore == expMax) else mismatch("classScore", expMax, classScore);
                assert (busy) else mismatch("busy", 1, busy);
                finished = 1'b1;
            end
        end
        @(negedge Clk);
        assert (!done) else mismatch("done", 0, done);
        assert (!busy) else mismatch("busy", 0, busy);
    endtask

    task automatic expectQuiet(input int numCycles);
        repeat (numCycles) begin
            @(negedge Clk);
            assert (!score.valid && !busy) else failRun("layer active after the run ended");
        end
    endtask

    task automatic abortRun();
        @(posedge Clk);
        #2;
        start = 1'b1;
        @(posedge Clk);
        #2;
        start = 1'b0;
        // Reset edges fall on the cycles of the last score and of done
        repeat (NUM_NEURONS * 35 - 3) @(posedge Clk);
        #2;
        resetReq = 1'b1;
        @(posedge Clk);
        @(negedge Clk);
        assert (!busy && !done && !score.valid) else failRun("outputs not idle during reset");
        @(posedge Clk);
        #2;
        resetReq = 1'b0;
        @(negedge Clk);
        assert (!busy && !done && !score.valid) else failRun("outputs not idle after reset");
    endtask

    //////////////////////////////
    // Stimulus and verdict
    //////////////////////////////
    always @(negedge Clk) begin
        if (boundFailures() != 0) begin
            failRun("a bound assertion failed");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge Clk);
        failRun("watchdog expired before all runs finished");
    end

    initial begin
        resetReq = 1'b0;
        start    = 1'b0;
        weightWr = '0;
        pixelWr  = '0;
        wait (rstN === 1'b1);
        @(negedge Clk);
        assert (!busy && !done && !score.valid) else failRun("outputs not idle after reset");
        assert (classIdx == '0) else mismatch("classIdx", 0, classIdx);
        assert (classScore == '0) else mismatch("classScore", 0, classScore);

        for (int a = 0; a < NUM_TAPS * NUM_NEURONS; a++) begin
            writeWeight(a, randByte());
        end
        stopWrites();
        loadPixels();
        runLayer(1'b0);

        // New pixels with the same weights and an ignored start
        loadPixels();
        runLayer(1'b1);
        expectQuiet(40);

        loadTieRows();
        runLayer(1'b0);

        abortRun();
        loadPixels();
        runLayer(1'b0);

        if (boundFailures() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            failRun("bound assertions reported failures");
        end
    end

endmodule

`default_nettype wire

/* dv/outLayer_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module outLayerAssert import nnTypesPkg::*; #(
    parameter bit CheckTop = 1'b0
) (
    input wire logic                Clk,
    input wire logic                rstN,
    input wire logic                aguReq,
    input wire logic                aguAck,
    input wire logic                aguDone,
    input wire logic [NEURON_W-1:0] neuronIdx,
    input tapT                      tap,
    input wire logic                busy,
    input wire logic                done,
    input neuronScoreT              score,
    input weightWrT                 weightWr,
    input pixelWrT                  pixelWr
);

    int unsigned failCount = 0;

    if (CheckTop) begin : gTop
        // Score pipeline latency, counted from the request
        scoreAfterReq: assert property (@(posedge Clk) disable iff (!rstN)
            aguReq |-> ##33 score.valid)
            else begin
                $error("score missing 33 cycles after aguReq");
                failCount++;
            end
        reqBeforeScore: assert property (@(posedge Clk) disable iff (!rstN)
            score.valid |-> $past(aguReq, 33))
            else begin
                $error("score without aguReq 33 cycles earlier");
                failCount++;
            end
        // Memories stay frozen during a run
        noLoadWhileBusy: assert property (@(posedge Clk) disable iff (!rstN)
            busy |-> !weightWr.en && !pixelWr.en)
            else begin
                $error("memory write strobe while busy");
                failCount++;
            end
        donePulse: assert property (@(posedge Clk) disable iff (!rstN)
            done |=> !done && !busy)
            else begin
                $error("done longer than one cycle or busy stuck");
                failCount++;
            end
    end else begin : gAgu
        sweepStart: assert property (@(posedge Clk) disable iff (!rstN)
            aguReq |=> tap.valid && tap.first && (tap.tapIdx == 0))
            else begin
                $error("sweep did not start on tap 0");
                failCount++;
            end
        sweepStep: assert property (@(posedge Clk) disable iff (!rstN)
            tap.valid && !tap.last |=> tap.valid && !tap.first
                && (tap.tapIdx == $past(tap.tapIdx) + 1))
            else begin
                $error("tap sweep broke before tap 29");
                failCount++;
            end
        tapFields: assert property (@(posedge Clk) disable iff (!rstN)
            tap.valid |-> (tap.last == (tap.tapIdx == NUM_TAPS - 1))
                && (tap.wAddr == neuronIdx * NUM_TAPS + tap.tapIdx))
            else begin
                $error("wrong last flag or weight address");
                failCount++;
            end
        doneAfterSweep: assert property (@(posedge Clk) disable iff (!rstN)
            tap.valid && tap.last |=> !tap.valid && aguDone)
            else begin
                $error("aguDone did not follow the last tap");
                failCount++;
            end
        doneHeld: assert property (@(posedge Clk) disable iff (!rstN)
            aguDone && !aguAck |=> aguDone)
            else begin
                $error("aguDone dropped before aguAck");
                failCount++;
            end
        doneCleared: assert property (@(posedge Clk) disable iff (!rstN)
            aguAck |=> !aguDone)
            else begin
                $error("aguDone still high after aguAck");
                failCount++;
            end
    end

endmodule

bind outLayerTop outLayerAssert #(.CheckTop(1'b1)) topChecks (.*);

bind outLayerAgu outLayerAssert #(.CheckTop(1'b0)) aguChecks (
    .busy     (1'b0),
    .done     (1'b0),
    .score    ('0),
    .weightWr ('0),
    .pixelWr  ('0),
    .*
);

`default_nettype wire

/* dv/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 2
) (
    input  wire logic resetReq,
    output logic      Clk,
    output logic      rstN
);

    logic porDone;

    initial begin
        Clk     = 1'b0;
        porDone = 1'b0;
        repeat (ResetCycles) @(posedge Clk);
        #2 porDone = 1'b1;
    end

    always #(PeriodNs / 2) Clk = ~Clk;

    // Power-on reset, or a reset requested mid-test
    assign rstN = porDone && !resetReq;

endmodule

`default_nettype wire

/* logic/outLayerTop.sv */
`timescale 1ns/1ps
`default_nettype none

module outLayerTop import nnTypesPkg::*; (
    input  wire logic                Clk,
    input  wire logic                rstN,
    input  weightWrT                 weightWr,
    input  pixelWrT                  pixelWr,
    input  wire logic                start,
    output logic                     busy,
    output logic                     done,
    output neuronScoreT              score,
    output logic [NEURON_W-1:0]      classIdx,
    output logic signed [ACC_W-1:0]  classScore
);

    logic                     aguReq;
    logic                     aguAck;
    logic                     aguDone;
    logic                     runStart;
    logic [NEURON_W-1:0]      neuronIdx;
    tapT                      tap;
    tapT                      tapDly;
    logic signed [DATA_W-1:0] weight;
    logic signed [DATA_W-1:0] pixel;
    tapDataT                  tapData;
    neuronScoreT              macScore;

    //////////////////////////////
    // Tap generation and fetch
    //////////////////////////////
    outLayerAgu uAgu (
        .Clk       (Clk),
        .rstN      (rstN),
        .aguReq    (aguReq),
        .neuronIdx (neuronIdx),
        .aguAck    (aguAck),
        .tap       (tap),
        .aguDone   (aguDone)
    );

    weightMem uWeightMem (
        .Clk      (Clk),
        .weightWr (weightWr),
        .tap      (tap),
        .weight   (weight),
        .tapOut   (tapDly)
    );

    pixelBuf uPixelBuf (
        .Clk     (Clk),
        .pixelWr (pixelWr),
        .tap     (tap),
        .pixel   (pixel)
    );

    // Both reads land in the same cycle
    assign tapData = '{
        valid:  tapDly.valid,
        first:  tapDly.first,
        last:   tapDly.last,
        weight: weight,
        pixel:  pixel
    };

    //////////////////////////////
    // Datapath and control
    //////////////////////////////
    macUnit uMac (
        .Clk      (Clk),
        .rstN     (rstN),
        .tapData  (tapData),
        .macScore (macScore)
    );

    layerSeq uSeq (
        .Clk       (Clk),
        .rstN      (rstN),
        .start     (start),
        .aguDone   (aguDone),
        .macScore  (macScore),
        .aguReq    (aguReq),
        .neuronIdx (neuronIdx),
        .aguAck    (aguAck),
        .runStart  (runStart),
        .score     (score),
        .busy      (busy),
        .done      (done)
    );

    argmaxSel uArgmax (
        .Clk        (Clk),
        .rstN       (rstN),
        .runStart   (runStart),
        .score      (score),
        .classIdx   (classIdx),
        .classScore (classScore)
    );

endmodule

`default_nettype wire

/* logic/layerSeq.sv */
`timescale 1ns/1ps
`default_nettype none

module layerSeq import nnTypesPkg::*, olCtrlPkg::*; (
    input  wire logic           Clk,
    input  wire logic           rstN,
    input  wire logic           start,
    input  wire logic           aguDone,
    input  neuronScoreT         macScore,
    output logic                aguReq,
    output logic [NEURON_W-1:0] neuronIdx,
    output logic                aguAck,
    output logic                runStart,
    output neuronScoreT         score,
    output logic                busy,
    output logic                done
);

    seqStateT state;
    logic     lastNeuron;

    assign lastNeuron = (neuronIdx == NEURON_W'(NUM_NEURONS - 1));

    assign aguReq = (state == seqIssue);
    // Sweep ends at least two cycles before the score shows up
    assign aguAck = (state == seqAck) && aguDone;

    // Stamp the score with the neuron being worked on
    always_comb begin
        score       = macScore;
        score.valid = macScore.valid && (state == seqWait);
        score.idx   = neuronIdx;
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state     <= seqIdle;
            neuronIdx <= '0;
            runStart  <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            runStart <= 1'b0;
            done     <= 1'b0;
            case (state)
                seqIdle: begin
                    if (start) begin
                        state     <= seqIssue;
                        neuronIdx <= '0;
                        runStart  <= 1'b1;
                        busy      <= 1'b1;
                    end
                end

                seqIssue: begin
                    state <= seqWait;
                end

                seqWait: begin
                    if (score.valid) begin
                        state <= seqAck;
                        done  <= lastNeuron;
                    end
                end

                seqAck: begin
                    if (aguDone) begin
                        if (lastNeuron) begin
                            state <= seqIdle;
                            busy  <= 1'b0;
                        end else begin
                            state     <= seqIssue;
                            neuronIdx <= neuronIdx + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= seqIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/argmaxSel.sv */
`timescale 1ns/1ps
`default_nettype none

module argmaxSel import nnTypesPkg::*; (
    input  wire logic                Clk,
    input  wire logic                rstN,
    input  wire logic                runStart,
    input  neuronScoreT              score,
    output logic [NEURON_W-1:0]      classIdx,
    output logic signed [ACC_W-1:0]  classScore
);

    // Set once the run has seen its first score
    logic haveMax;
    logic takeNew;

    // Strict compare, equal scores keep the earlier neuron
    assign takeNew = score.valid && (!haveMax || (score.value > classScore));

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            haveMax    <= 1'b0;
            classIdx   <= '0;
            classScore <= '0;
        end else if (runStart) begin
            haveMax <= 1'b0;
        end else if (takeNew) begin
            haveMax    <= 1'b1;
            classIdx   <= score.idx;
            classScore <= score.value;
        end
    end

endmodule

`default_nettype wire

/* logic/macUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module macUnit import nnTypesPkg::*; (
    input  wire logic Clk,
    input  wire logic rstN,
    input  tapDataT   tapData,
    output neuronScoreT macScore
);

    logic                       prodValid;
    logic                       prodFirst;
    logic                       prodLast;
    logic signed [2*DATA_W-1:0] prod;
    logic signed [ACC_W-1:0]    acc;
    logic                       scoreValid;

    // Stage 1, product register
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            prodValid <= 1'b0;
            prodFirst <= 1'b0;
            prodLast  <= 1'b0;
        end else begin
            prodValid <= tapData.valid;
            prodFirst <= tapData.first;
            prodLast  <= tapData.last;
        end
        prod <= tapData.weight * tapData.pixel;
    end

    // Stage 2, accumulate
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            scoreValid <= 1'b0;
        end else begin
            scoreValid <= prodValid && prodLast;
        end
        if (prodValid) begin
            // First tap reloads, so the next neuron can follow directly
            acc <= prodFirst ? ACC_W'(prod) : acc + ACC_W'(prod);
        end
    end

    assign macScore.valid = scoreValid;
    assign macScore.idx   = '0;
    assign macScore.value = acc;

endmodule

`default_nettype wire

/* logic/pixelBuf.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelBuf import nnTypesPkg::*; (
    input  wire logic                Clk,
    input  pixelWrT                  pixelWr,
    input  tapT                      tap,
    output logic signed [DATA_W-1:0] pixel
);

    logic signed [DATA_W-1:0] pixRegs [NUM_TAPS];

    // Indices past the last pixel are dropped
    always_ff @(posedge Clk) begin
        if (pixelWr.en && (pixelWr.idx < TAP_W'(NUM_TAPS))) begin
            pixRegs[pixelWr.idx] <= pixelWr.data;
        end
    end

    // Same pixel set is shared by every neuron
    always_ff @(posedge Clk) begin
        pixel <= pixRegs[tap.tapIdx];
    end

endmodule

`default_nettype wire

/* logic/weightMem.sv */
`timescale 1ns/1ps
`default_nettype none

module weightMem import nnTypesPkg::*; (
    input  wire logic                Clk,
    input  weightWrT                 weightWr,
    input  tapT                      tap,
    output logic signed [DATA_W-1:0] weight,
    output tapT                      tapOut
);

    // Ten rows of thirty weights, row per neuron
    logic signed [DATA_W-1:0] mem [NUM_TAPS*NUM_NEURONS];

    //////////////////////////////
    // Load port
    //////////////////////////////
    always_ff @(posedge Clk) begin
        if (weightWr.en && (weightWr.addr < W_ADDR_W'(NUM_TAPS * NUM_NEURONS))) begin
            mem[weightWr.addr] <= weightWr.data;
        end
    end

    //////////////////////////////
    // Tap read
    //////////////////////////////
    always_ff @(posedge Clk) begin
        weight <= mem[tap.wAddr];
        // Flags ride along with the read data
        tapOut <= tap;
    end

endmodule

`default_nettype wire

/* logic/outLayerAgu.sv */
`timescale 1ns/1ps
`default_nettype none

module outLayerAgu import nnTypesPkg::*, olCtrlPkg::*; (
    input  wire logic                Clk,
    input  wire logic                rstN,
    input  wire logic                aguReq,
    input  wire logic [NEURON_W-1:0] neuronIdx,
    input  wire logic                aguAck,
    output tapT                      tap,
    output logic                     aguDone
);

    aguStateT state;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state   <= aguIdle;
            tap     <= '0;
            aguDone <= 1'b0;
        end else begin
            case (state)
                aguIdle: begin
                    if (aguReq) begin
                        state      <= aguSweep;
                        tap.valid  <= 1'b1;
                        tap.first  <= 1'b1;
                        tap.last   <= 1'b0;
                        tap.tapIdx <= '0;
                        // Base of this neuron's weight row
                        tap.wAddr  <= W_ADDR_W'(neuronIdx) * W_ADDR_W'(NUM_TAPS);
                    end
                end

                aguSweep: begin
                    if (tap.last) begin
                        state     <= aguHold;
                        tap.valid <= 1'b0;
                        tap.first <= 1'b0;
                        tap.last  <= 1'b0;
                        aguDone   <= 1'b1;
                    end else begin
                        tap.first  <= 1'b0;
                        // Flag the final tap one cycle ahead
                        tap.last   <= (tap.tapIdx == TAP_W'(NUM_TAPS - 2));
                        tap.tapIdx <= tap.tapIdx + 1'b1;
                        tap.wAddr  <= tap.wAddr + 1'b1;
                    end
                end

                aguHold: begin
                    if (aguAck) begin
                        state   <= aguIdle;
                        aguDone <= 1'b0;
                    end
                end

                default: begin
                    state <= aguIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/olCtrlPkg.sv */
`default_nettype none

package olCtrlPkg;

    // Address generator: wait, sweep thirty taps, hold done
    typedef enum logic [1:0] {
        aguIdle,
        aguSweep,
        aguHold
    } aguStateT;

    // Layer sequencer, one pass through issue/wait/ack per neuron
    typedef enum logic [1:0] {
        seqIdle,
        seqIssue,
        seqWait,
        seqAck
    } seqStateT;

endpackage

`default_nettype wire

/* logic/nnTypesPkg.sv */
`default_nettype none

package nnTypesPkg;

    //////////////////////////////
    // Layer dimensions and widths
    //////////////////////////////
    localparam int NUM_TAPS    = 30;
    localparam int NUM_NEURONS = 10;
    localparam int DATA_W      = 8;
    localparam int ACC_W       = 24;
    localparam int W_ADDR_W    = 9;
    localparam int TAP_W       = 5;
    localparam int NEURON_W    = 4;

    // External load strobes
    typedef struct packed {
        logic                     en;
        logic [W_ADDR_W-1:0]      addr;
        logic signed [DATA_W-1:0] data;
    } weightWrT;

    typedef struct packed {
        logic                     en;
        logic [TAP_W-1:0]         idx;
        logic signed [DATA_W-1:0] data;
    } pixelWrT;

    // One read tap from the address generator
    typedef struct packed {
        logic                valid;
        logic                first;
        logic                last;
        logic [W_ADDR_W-1:0] wAddr;
        logic [TAP_W-1:0]    tapIdx;
    } tapT;

    // Tap after both memory reads
    typedef struct packed {
        logic                     valid;
        logic                     first;
        logic                     last;
        logic signed [DATA_W-1:0] weight;
        logic signed [DATA_W-1:0] pixel;
    } tapDataT;

    typedef struct packed {
        logic                    valid;
        logic [NEURON_W-1:0]     idx;
        logic signed [ACC_W-1:0] value;
    } neuronScoreT;

endpackage

`default_nettype wire
